/* compile.f */
+incdir+include
design/phy_types_pkg.sv
design/enc_8b10b.sv
design/flit_encoder.sv
design/tx_arbiter.sv
design/packet_framer.sv
design/link_ctrl_gen.sv
design/phy_tx_top.sv
dv/phy_tx_props.sv
dv/phy_tx_tb.sv

/* run.sh */
#!/bin/sh
# build and run the PHY tx testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module phy_tx_tb -o phy_tx_sim > build.log 2>&1 \
    && ./obj_dir/phy_tx_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
! grep -q "Finished with errors" sim.log \
    && grep -q "Finished with no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* dv/phy_tx_tb.sv */
// ==================================================
// table driven testbench for the link PHY tx top
// checks every flit against a reference 8b/10b model
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "phy_link_params.svh"

module phy_tx_tb import phy_types_pkg::*;;

    localparam int LIMIT = 2000;
    localparam int NROWS = 10;

    // stimulus table with one event per row
    localparam int         ROW_WORDS [NROWS] = '{1, 4, 0, 0, 0, 0, 0, 0, 6, 8};
    localparam bit         ROW_CTL   [NROWS] = '{0, 0, 1, 1, 1, 1, 1, 1, 1, 1};
    localparam comma_sel_t ROW_KIND  [NROWS] = '{ACK_SEL, ACK_SEL, ACK_SEL, NACK_SEL,
        RESEND_PACKET0_SEL, RESEND_PACKET1_SEL, RESEND_PACKET2_SEL, RESEND_PACKET3_SEL,
        ACK_SEL, NACK_SEL};
    localparam logic [7:0] ROW_SEQ   [NROWS] = '{8'h00, 8'h00, 8'h00, 8'h5a, 8'h17,
        8'hf1, 8'h3c, 8'hff, 8'h81, 8'h2e};
    // cycles into the packet before the control request
    localparam int         ROW_DELAY [NROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 3, 5};
    localparam bit         ROW_STALL [NROWS] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 1};
    // expected flits are k+2 per packet plus one per control
    localparam int         ROW_FLITS [NROWS] = '{3, 6, 1, 1, 1, 1, 1, 1, 9, 11};

    // 5b/6b and 3b/4b codes in the RD- column
    localparam logic [5:0] CODE6 [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011};
    localparam logic [3:0] CODE4 [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};

    logic                   CLK;
    logic                   nRST;
    logic                   pkt_valid;
    logic                   pkt_ready;
    tx_word_t               pkt_data;
    logic                   pkt_last;
    logic                   ctl_valid;
    logic                   ctl_ready;
    comma_sel_t             ctl_kind;
    seq_t                   ctl_seq;
    logic                   flit_valid;
    logic                   flit_ready = 1'b0;
    logic [`PHY_FLIT_W-1:0] flit_out;
    comma_length_sel_t      comma_length_sel_out;

    integer     seed = 5;
    int         err_count = 0;
    int         check_count = 0;
    int         seen_count = 0;
    int         exp_total = 0;
    bit         timed_out = 1'b0;
    bit         stall_en = 1'b0;
    string      test_name = "reset";
    // per symbol slot disparity where 1 is RD+
    logic [4:0] rd_track = 5'b0;
    // packet flits seen in the current row
    int         pkt_seen_row = 0;
    // packet flits that went out ahead of the control flit
    int         ctl_pos = -1;

    // expected flits still outstanding
    comma_sel_t pkt_sel_q[$];
    tx_word_t   pkt_word_q[$];
    comma_sel_t ctl_sel_q[$];
    seq_t       ctl_seq_q[$];

    phy_tx_top phy_tx_top_inst (
        .CLK(CLK), .nRST(nRST),
        .pkt_valid(pkt_valid), .pkt_ready(pkt_ready),
        .pkt_data(pkt_data), .pkt_last(pkt_last),
        .ctl_valid(ctl_valid), .ctl_ready(ctl_ready),
        .ctl_kind(ctl_kind), .ctl_seq(ctl_seq),
        .flit_valid(flit_valid), .flit_ready(flit_ready),
        .flit_out(flit_out), .comma_length_sel_out(comma_length_sel_out)
    );

    bind phy_tx_top phy_tx_props phy_tx_props_inst (
        .CLK(CLK), .nRST(nRST),
        .flit_valid(flit_valid), .flit_ready(flit_ready),
        .flit_out(flit_out), .comma_length_sel_out(comma_length_sel_out),
        .enc_valid(enc_valid), .enc_ready(enc_ready),
        .enc_sel(enc_sel), .enc_data(enc_data)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // reference encoder returning {rd_after, abcdei, fghj}
    function automatic logic [10:0] enc_ref(input logic [7:0] b, input logic rd);
        logic [4:0] x;
        logic [2:0] y;
        logic [5:0] c6;
        logic [3:0] c4;
        logic       r;
        x  = b[4:0];
        y  = b[7:5];
        r  = rd;
        c6 = CODE6[x];
        if (r && (($countones(c6) != 3) || (x == 5'd7))) c6 = ~c6;
        if ($countones(c6) != 3) r = ~r;
        c4 = CODE4[y];
        // A7 keeps runs of equal bits at four or less
        if ((y == 3'd7) && ((!r && ((x == 5'd17) || (x == 5'd18) || (x == 5'd20))) ||
                            (r && ((x == 5'd11) || (x == 5'd13) || (x == 5'd14)))))
            c4 = 4'b0111;
        if (r && (($countones(c4) != 2) || (y == 3'd3))) c4 = ~c4;
        if ($countones(c4) != 2) r = ~r;
        return {r, c6, c4};
    endfunction

    function automatic logic [9:0] comma_for(input comma_sel_t sel);
        case (sel)
            START_PACKET_SEL:   return START_COMMA;
            END_PACKET_SEL:     return END_COMMA;
            RESEND_PACKET0_SEL: return RESEND_PACKET0_COMMA;
            RESEND_PACKET1_SEL: return RESEND_PACKET1_COMMA;
            RESEND_PACKET2_SEL: return RESEND_PACKET2_COMMA;
            RESEND_PACKET3_SEL: return RESEND_PACKET3_COMMA;
            ACK_SEL:            return ACK_COMMA;
            NACK_SEL:           return NACK_COMMA;
            default:            return 10'h000;
        endcase
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // compare one transferred flit with the next expected one
    task automatic check_flit();
        logic [`PHY_FLIT_W-1:0] exp;
        logic [10:0]            r;
        logic [4:0]             rd_n;
        comma_sel_t             sel;
        tx_word_t               w;
        seq_t                   s;
        seen_count++;
        if (comma_length_sel_out == SELECT_COMMA_2_FLIT) begin
            if (ctl_sel_q.size() == 0) begin
                err_count++;
                $display("%s: control flit seen with no control request pending", test_name);
            end else begin
                sel = ctl_sel_q.pop_front();
                s   = ctl_seq_q.pop_front();
                r   = enc_ref(s, rd_track[0]);
                exp = {comma_for(sel), r[9:0], {30{1'b1}}};
                check_val("control flit", 64'(exp), 64'(flit_out));
                rd_track[0] = r[10];
                ctl_pos     = pkt_seen_row;
            end
        end else if (pkt_sel_q.size() == 0) begin
            err_count++;
            $display("%s: packet flit seen with no packet flit expected", test_name);
        end else begin
            sel = pkt_sel_q.pop_front();
            w   = pkt_word_q.pop_front();
            pkt_seen_row++;
            if (sel == DATA_SEL) begin
                rd_n = rd_track;
                for (int i = 0; i < `PHY_BYTES; i++) begin
                    r = enc_ref(w[8*i +: 8], rd_track[i]);
                    exp[10*i +: 10] = r[9:0];
                    rd_n[i] = r[10];
                end
                rd_track = rd_n;
                check_val("data length", 64'(SELECT_COMMA_DATA), 64'(comma_length_sel_out));
            end else begin
                exp = {comma_for(sel), {40{1'b1}}};
                check_val("frame length", 64'(SELECT_COMMA_1_FLIT), 64'(comma_length_sel_out));
            end
            check_val("packet flit", 64'(exp), 64'(flit_out));
        end
    endtask

    // output monitor
    always @(posedge CLK) begin
        if (nRST && flit_valid && flit_ready) begin
            check_flit();
        end
    end

    // back-pressure on the flit output
    always @(posedge CLK) begin
        #5;
        if (stall_en) begin
            flit_ready = (($random(seed) & 3) != 0);
        end else if (nRST) begin
            flit_ready = 1'b1;
        end
    end

    task automatic note_timeout(input string what);
        err_count++;
        timed_out = 1'b1;
        $display("%s: timed out waiting for %s", test_name, what);
    endtask

    // one word per handshake with START and END around them
    task automatic send_packet(input int n);
        logic [31:0] hi;
        logic [31:0] lo;
        int          cnt;
        pkt_sel_q.push_back(START_PACKET_SEL);
        pkt_word_q.push_back('0);
        for (int i = 0; i < n && !timed_out; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            pkt_valid = 1'b1;
            pkt_data  = {hi[7:0], lo};
            pkt_last  = (i == n - 1);
            pkt_sel_q.push_back(DATA_SEL);
            pkt_word_q.push_back(pkt_data);
            cnt = 0;
            do begin
                @(posedge CLK);
                cnt++;
                if (cnt > LIMIT) note_timeout("pkt_ready");
            end while (!pkt_ready && !timed_out);
            #5;
        end
        pkt_sel_q.push_back(END_PACKET_SEL);
        pkt_word_q.push_back('0);
        pkt_valid = 1'b0;
        pkt_last  = 1'b0;
    endtask

    task automatic send_ctl(input comma_sel_t kind, input seq_t seq);
        int cnt;
        ctl_valid = 1'b1;
        ctl_kind  = kind;
        ctl_seq   = seq;
        cnt = 0;
        do begin
            @(posedge CLK);
            cnt++;
            if (cnt > LIMIT) note_timeout("ctl_ready");
        end while (!ctl_ready && !timed_out);
        ctl_sel_q.push_back(kind);
        ctl_seq_q.push_back(seq);
        #5;
        ctl_valid = 1'b0;
    endtask

    task automatic wait_flits(input int target);
        int cnt;
        cnt = 0;
        while (seen_count < target && !timed_out) begin
            @(posedge CLK);
            #1;
            cnt++;
            if (cnt > LIMIT) note_timeout("output flits");
        end
        @(posedge CLK);
        #5;
    endtask

    initial begin
        nRST      = 1'b0;
        pkt_valid = 1'b0;
        pkt_data  = '0;
        pkt_last  = 1'b0;
        ctl_valid = 1'b0;
        ctl_kind  = ACK_SEL;
        ctl_seq   = '0;
        repeat (16) @(posedge CLK);
        #5;
        nRST = 1'b1;

        // idle state straight out of reset
        check_val("flit_valid", 64'(1'b0), 64'(flit_valid));
        check_val("length select", 64'(SELECT_COMMA_1_FLIT), 64'(comma_length_sel_out));
        check_val("ctl_ready", 64'(1'b1), 64'(ctl_ready));
        check_val("pkt_ready", 64'(1'b0), 64'(pkt_ready));
        @(posedge CLK);
        #5;

        for (int r = 0; r < NROWS && !timed_out; r++) begin
            test_name    = $sformatf("row%0d", r);
            stall_en     = ROW_STALL[r];
            exp_total   += ROW_FLITS[r];
            pkt_seen_row = 0;
            ctl_pos      = -1;
            fork
                begin
                    if (ROW_WORDS[r] > 0) send_packet(ROW_WORDS[r]);
                end
                begin
                    if (ROW_CTL[r]) begin
                        repeat (ROW_DELAY[r]) @(posedge CLK);
                        if (ROW_DELAY[r] > 0) #5;
                        send_ctl(ROW_KIND[r], ROW_SEQ[r]);
                    end
                end
            join
            wait_flits(exp_total);
            // control flit must sit after some data flit and before another one
            if (ROW_WORDS[r] > 0 && ROW_CTL[r]) begin
                check_count++;
                if (ctl_pos < 2 || ctl_pos > ROW_WORDS[r]) begin
                    err_count++;
                    $display("%s: control flit not between data flits, %0d packet flits before it",
                             test_name, ctl_pos);
                end
            end
        end

        // nothing extra may trail the last row
        stall_en  = 1'b0;
        test_name = "totals";
        repeat (10) @(posedge CLK);
        #1;
        check_val("flit count", 64'(exp_total), 64'(seen_count));
        check_val("packet flits left", 64'(0), 64'(pkt_sel_q.size()));
        check_val("control flits left", 64'(0), 64'(ctl_sel_q.size()));

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/phy_tx_props.sv */
// ==================================================
// handshake and reset assertions for the PHY tx top
// bound onto phy_tx_top from the testbench
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "phy_link_params.svh"

module phy_tx_props import phy_types_pkg::*; (
    input logic                   CLK,
    input logic                   nRST,
    input logic                   flit_valid,
    input logic                   flit_ready,
    input logic [`PHY_FLIT_W-1:0] flit_out,
    input comma_length_sel_t      comma_length_sel_out,
    input logic                   enc_valid,
    input logic                   enc_ready,
    input comma_sel_t             enc_sel,
    input tx_word_t               enc_data
);

    // stalled output flit must hold
    flit_hold_a: assert property (@(posedge CLK) disable iff (!nRST)
        flit_valid && !flit_ready |=>
            flit_valid && $stable(flit_out) && $stable(comma_length_sel_out))
        else $error("flit output changed while stalled");

    // granted request must hold until the encoder takes it
    enc_hold_a: assert property (@(posedge CLK) disable iff (!nRST)
        enc_valid && !enc_ready |=> enc_valid && $stable(enc_sel) && $stable(enc_data))
        else $error("encoder request changed while stalled");

    // no flit leaves while in reset
    reset_idle_a: assert property (@(posedge CLK) !nRST |-> !flit_valid)
        else $error("flit_valid high during reset");

endmodule

`default_nettype wire

/* design/phy_tx_top.sv */
// ==================================================
// link PHY transmit top, framer and control generator
// share the flit encoder through the arbiter
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module phy_tx_top import phy_types_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              pkt_valid,
    output logic              pkt_ready,
    input  tx_word_t          pkt_data,
    input  logic              pkt_last,
    input  logic              ctl_valid,
    output logic              ctl_ready,
    input  comma_sel_t        ctl_kind,
    input  seq_t              ctl_seq,
    output logic              flit_valid,
    input  logic              flit_ready,
    output logic [49:0]       flit_out,
    output comma_length_sel_t comma_length_sel_out
);

    // control peer
    logic       ctl_req_valid;
    logic       ctl_req_ready;
    comma_sel_t ctl_req_sel;
    tx_word_t   ctl_req_data;
    // data peer
    logic       dat_req_valid;
    logic       dat_req_ready;
    comma_sel_t dat_req_sel;
    tx_word_t   dat_req_data;
    // granted request
    logic       enc_valid;
    logic       enc_ready;
    comma_sel_t enc_sel;
    tx_word_t   enc_data;

    packet_framer packet_framer_inst (
        .CLK(CLK), .nRST(nRST),
        .pkt_valid(pkt_valid), .pkt_ready(pkt_ready),
        .pkt_data(pkt_data), .pkt_last(pkt_last),
        .req_valid(dat_req_valid), .req_ready(dat_req_ready),
        .req_sel(dat_req_sel), .req_data(dat_req_data)
    );

    link_ctrl_gen link_ctrl_gen_inst (
        .CLK(CLK), .nRST(nRST),
        .ctl_valid(ctl_valid), .ctl_ready(ctl_ready),
        .ctl_kind(ctl_kind), .ctl_seq(ctl_seq),
        .req_valid(ctl_req_valid), .req_ready(ctl_req_ready),
        .req_sel(ctl_req_sel), .req_data(ctl_req_data)
    );

    tx_arbiter tx_arbiter_inst (
        .CLK(CLK), .nRST(nRST),
        .ctl_req_valid(ctl_req_valid), .ctl_req_ready(ctl_req_ready),
        .ctl_req_sel(ctl_req_sel), .ctl_req_data(ctl_req_data),
        .dat_req_valid(dat_req_valid), .dat_req_ready(dat_req_ready),
        .dat_req_sel(dat_req_sel), .dat_req_data(dat_req_data),
        .enc_valid(enc_valid), .enc_ready(enc_ready),
        .enc_sel(enc_sel), .enc_data(enc_data)
    );

    flit_encoder flit_encoder_inst (
        .CLK(CLK), .nRST(nRST),
        .enc_valid(enc_valid), .enc_ready(enc_ready),
        .enc_sel(enc_sel), .enc_data(enc_data),
        .flit_valid(flit_valid), .flit_ready(flit_ready),
        .flit_out(flit_out), .comma_length_sel_out(comma_length_sel_out)
    );

endmodule

`default_nettype wire

/* design/link_ctrl_gen.sv */
// ==================================================
// one-slot holder for ACK, NACK and RESEND requests
// presents the held request as a control flit request
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module link_ctrl_gen import phy_types_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       ctl_valid,
    output logic       ctl_ready,
    input  comma_sel_t ctl_kind,
    input  seq_t       ctl_seq,
    output logic       req_valid,
    input  logic       req_ready,
    output comma_sel_t req_sel,
    output tx_word_t   req_data
);

    logic       slot_full;
    comma_sel_t kind_q;
    seq_t       seq_q;

    // slot free means a new request can land
    assign ctl_ready = !slot_full;
    assign req_valid = slot_full;
    assign req_sel   = kind_q;

    // sequence number rides in the low byte
    always_comb begin
        req_data      = '0;
        req_data[7:0] = seq_q;
    end

    // slot occupancy
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            slot_full <= 1'b0;
        end else if (ctl_valid && ctl_ready) begin
            slot_full <= 1'b1;
        end else if (req_valid && req_ready) begin
            slot_full <= 1'b0;
        end
    end

    // held kind and sequence
    always_ff @(posedge CLK) begin
        if (ctl_valid && ctl_ready) begin
            kind_q <= ctl_kind;
            seq_q  <= ctl_seq;
        end
    end

endmodule

`default_nettype wire

/* design/packet_framer.sv */
// ==================================================
// wraps a user packet as START, DATA per word, END
// one accepted flit per step, words pass straight through
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module packet_framer import phy_types_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       pkt_valid,
    output logic       pkt_ready,
    input  tx_word_t   pkt_data,
    input  logic       pkt_last,
    output logic       req_valid,
    input  logic       req_ready,
    output comma_sel_t req_sel,
    output tx_word_t   req_data
);

    typedef enum logic [1:0] {IDLE, START, DATA, END} framer_state_t;

    framer_state_t state;
    framer_state_t state_nxt;

    // outputs and next state
    always_comb begin
        state_nxt = state;
        req_valid = 1'b0;
        req_sel   = START_PACKET_SEL;
        req_data  = '0;
        pkt_ready = 1'b0;
        case (state)
            IDLE: begin
                // first word waiting opens a packet
                if (pkt_valid) begin
                    state_nxt = START;
                end
            end
            START: begin
                req_valid = 1'b1;
                if (req_ready) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                req_valid = pkt_valid;
                req_sel   = DATA_SEL;
                req_data  = pkt_data;
                pkt_ready = req_ready;
                // last word taken, close the packet
                if (pkt_valid && req_ready && pkt_last) begin
                    state_nxt = END;
                end
            end
            default: begin
                req_valid = 1'b1;
                req_sel   = END_PACKET_SEL;
                if (req_ready) begin
                    state_nxt = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

/* design/tx_arbiter.sv */
// ==================================================
// two-way fixed-priority arbiter ahead of the encoder
// link control beats packet data, shown data is locked
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter import phy_types_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       ctl_req_valid,
    output logic       ctl_req_ready,
    input  comma_sel_t ctl_req_sel,
    input  tx_word_t   ctl_req_data,
    input  logic       dat_req_valid,
    output logic       dat_req_ready,
    input  comma_sel_t dat_req_sel,
    input  tx_word_t   dat_req_data,
    output logic       enc_valid,
    input  logic       enc_ready,
    output comma_sel_t enc_sel,
    output tx_word_t   enc_data
);

    logic dat_lock;
    logic grant_ctl;

    // control wins unless a stalled data flit is already on the bus
    assign grant_ctl = ctl_req_valid && !dat_lock;

    assign enc_valid     = grant_ctl || dat_req_valid;
    assign enc_sel       = grant_ctl ? ctl_req_sel : dat_req_sel;
    assign enc_data      = grant_ctl ? ctl_req_data : dat_req_data;
    assign ctl_req_ready = grant_ctl && enc_ready;
    assign dat_req_ready = !grant_ctl && enc_ready;

    // lock while data is shown but not taken
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            dat_lock <= 1'b0;
        end else begin
            dat_lock <= dat_req_valid && !grant_ctl && !enc_ready;
        end
    end

endmodule

`default_nettype wire

/* design/flit_encoder.sv */
// ==================================================
// turns a granted request into a 50-bit line flit
// one output register behind a valid/ready handshake
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "phy_link_params.svh"

module flit_encoder import phy_types_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   enc_valid,
    output logic                   enc_ready,
    input  comma_sel_t             enc_sel,
    input  tx_word_t               enc_data,
    output logic                   flit_valid,
    input  logic                   flit_ready,
    output logic [`PHY_FLIT_W-1:0] flit_out,
    output comma_length_sel_t      comma_length_sel_out
);

    logic [`PHY_FLIT_W-1:0] flit_norm;
    logic [`PHY_FLIT_W-1:0] n_flit;
    comma_length_sel_t      n_len;
    logic [`PHY_SYM_W-1:0]  ctl_comma;
    logic [`PHY_BYTES-1:0]  sym_adv;
    logic                   accept;
    logic                   is_data;
    logic                   is_ctl;

    // free slot, or the held flit leaves this cycle
    assign enc_ready = !flit_valid || flit_ready;
    assign accept    = enc_valid && enc_ready;

    // byte i lands in symbol slot i
    for (genvar i = 0; i < `PHY_BYTES; i++) begin : g_sym
        // control flits consume symbol 0 on the line too
        assign sym_adv[i] = accept && (is_data || ((i == 0) && is_ctl));

        enc_8b10b enc_inst (
            .CLK      (CLK),
            .nRST     (nRST),
            .advance  (sym_adv[i]),
            .data_in  (enc_data[8*i +: 8]),
            .data_out (flit_norm[`PHY_SYM_W*i +: `PHY_SYM_W])
        );
    end

    // flit kind decode
    always_comb begin
        n_flit    = '0;
        n_len     = SELECT_COMMA_1_FLIT;
        ctl_comma = '0;
        is_data   = 1'b0;
        is_ctl    = 1'b0;
        case (enc_sel)
            START_PACKET_SEL: begin
                n_flit = {START_COMMA, {(`PHY_FLIT_W-`PHY_SYM_W){1'b1}}};
            end
            END_PACKET_SEL: begin
                n_flit = {END_COMMA, {(`PHY_FLIT_W-`PHY_SYM_W){1'b1}}};
            end
            RESEND_PACKET0_SEL: begin
                ctl_comma = RESEND_PACKET0_COMMA;
                is_ctl    = 1'b1;
            end
            RESEND_PACKET1_SEL: begin
                ctl_comma = RESEND_PACKET1_COMMA;
                is_ctl    = 1'b1;
            end
            RESEND_PACKET2_SEL: begin
                ctl_comma = RESEND_PACKET2_COMMA;
                is_ctl    = 1'b1;
            end
            RESEND_PACKET3_SEL: begin
                ctl_comma = RESEND_PACKET3_COMMA;
                is_ctl    = 1'b1;
            end
            ACK_SEL: begin
                ctl_comma = ACK_COMMA;
                is_ctl    = 1'b1;
            end
            NACK_SEL: begin
                ctl_comma = NACK_COMMA;
                is_ctl    = 1'b1;
            end
            DATA_SEL: begin
                n_flit  = flit_norm;
                n_len   = SELECT_COMMA_DATA;
                is_data = 1'b1;
            end
            default: begin
            end
        endcase
        // comma, encoded sequence byte, then fill ones
        if (is_ctl) begin
            n_flit = {ctl_comma, flit_norm[`PHY_SYM_W-1:0],
                      {(`PHY_FLIT_W-2*`PHY_SYM_W){1'b1}}};
            n_len  = SELECT_COMMA_2_FLIT;
        end
    end

    // output slot control
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            flit_valid           <= 1'b0;
            comma_length_sel_out <= SELECT_COMMA_1_FLIT;
        end else if (accept) begin
            flit_valid           <= 1'b1;
            comma_length_sel_out <= n_len;
        end else if (flit_ready) begin
            flit_valid           <= 1'b0;
        end
    end

    // flit payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            flit_out <= n_flit;
        end
    end

endmodule

`default_nettype wire

/* design/enc_8b10b.sv */
// ==================================================
// single byte 8b/10b encoder
// running disparity steps only when advance is high
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module enc_8b10b (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       advance,
    input  logic [7:0] data_in,
    output logic [9:0] data_out
);

    // 1 = RD+, 0 = RD-
    logic       rd_pos;
    logic [4:0] x5;
    logic [2:0] y3;
    logic [5:0] code6_neg;
    logic [3:0] code4_neg;
    logic [5:0] code6;
    logic [3:0] code4;
    logic       unbal6;
    logic       rd_mid;
    logic       use_alt7;
    logic       flip4;
    logic       rd_next;

    // EDCBA and HGF halves
    assign x5 = data_in[4:0];
    assign y3 = data_in[7:5];

    // 5b/6b codes as seen from RD-
    always_comb begin
        case (x5)
            5'd0:    code6_neg = 6'b100111;
            5'd1:    code6_neg = 6'b011101;
            5'd2:    code6_neg = 6'b101101;
            5'd3:    code6_neg = 6'b110001;
            5'd4:    code6_neg = 6'b110101;
            5'd5:    code6_neg = 6'b101001;
            5'd6:    code6_neg = 6'b011001;
            5'd7:    code6_neg = 6'b111000;
            5'd8:    code6_neg = 6'b111001;
            5'd9:    code6_neg = 6'b100101;
            5'd10:   code6_neg = 6'b010101;
            5'd11:   code6_neg = 6'b110100;
            5'd12:   code6_neg = 6'b001101;
            5'd13:   code6_neg = 6'b101100;
            5'd14:   code6_neg = 6'b011100;
            5'd15:   code6_neg = 6'b010111;
            5'd16:   code6_neg = 6'b011011;
            5'd17:   code6_neg = 6'b100011;
            5'd18:   code6_neg = 6'b010011;
            5'd19:   code6_neg = 6'b110010;
            5'd20:   code6_neg = 6'b001011;
            5'd21:   code6_neg = 6'b101010;
            5'd22:   code6_neg = 6'b011010;
            5'd23:   code6_neg = 6'b111010;
            5'd24:   code6_neg = 6'b110011;
            5'd25:   code6_neg = 6'b100110;
            5'd26:   code6_neg = 6'b010110;
            5'd27:   code6_neg = 6'b110110;
            5'd28:   code6_neg = 6'b001110;
            5'd29:   code6_neg = 6'b101110;
            5'd30:   code6_neg = 6'b011110;
            default: code6_neg = 6'b101011;
        endcase
    end

    // four ones means the 6b code flips disparity
    assign unbal6 = ($countones(code6_neg) != 3);

    // D.7 is balanced but still has a mirrored RD+ form
    assign code6  = (rd_pos && (unbal6 || (x5 == 5'd7))) ? ~code6_neg : code6_neg;
    assign rd_mid = rd_pos ^ unbal6;

    // alternate D.x.7 avoids a run of five in abcdeifghj
    assign use_alt7 = (y3 == 3'd7) &&
                      ((!rd_mid && ((x5 == 5'd17) || (x5 == 5'd18) || (x5 == 5'd20))) ||
                       (rd_mid && ((x5 == 5'd11) || (x5 == 5'd13) || (x5 == 5'd14))));

    // 3b/4b codes as seen from RD-
    always_comb begin
        case (y3)
            3'd0:    code4_neg = 4'b1011;
            3'd1:    code4_neg = 4'b1001;
            3'd2:    code4_neg = 4'b0101;
            3'd3:    code4_neg = 4'b1100;
            3'd4:    code4_neg = 4'b1101;
            3'd5:    code4_neg = 4'b1010;
            3'd6:    code4_neg = 4'b0110;
            default: code4_neg = use_alt7 ? 4'b0111 : 4'b1110;
        endcase
    end

    // y = 0,3,4,7 have a separate RD+ form
    assign flip4 = rd_mid && ((y3 == 3'd0) || (y3 == 3'd3) || (y3 == 3'd4) || (y3 == 3'd7));
    assign code4 = flip4 ? ~code4_neg : code4_neg;

    // only the unbalanced 4b codes move disparity again
    assign rd_next = rd_mid ^ ((y3 == 3'd0) || (y3 == 3'd4) || (y3 == 3'd7));

    assign data_out = {code6, code4};

    // starts negative after reset
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_pos <= 1'b0;
        end else if (advance) begin
            rd_pos <= rd_next;
        end
    end

endmodule

`default_nettype wire

/* design/phy_types_pkg.sv */
// ==================================================
// shared types for the link PHY transmit path
// flit selects, length selects, comma codes
// ==================================================
`default_nettype none

`include "phy_link_params.svh"

package phy_types_pkg;

    // how the serializer should treat the outgoing flit
    typedef enum logic [1:0] {
        SELECT_COMMA_1_FLIT,
        SELECT_COMMA_2_FLIT,
        SELECT_COMMA_DATA
    } comma_length_sel_t;

    // flit kind requested by a peer
    typedef enum logic [3:0] {
        START_PACKET_SEL,
        END_PACKET_SEL,
        RESEND_PACKET0_SEL,
        RESEND_PACKET1_SEL,
        RESEND_PACKET2_SEL,
        RESEND_PACKET3_SEL,
        ACK_SEL,
        NACK_SEL,
        DATA_SEL
    } comma_sel_t;

    // K28.x codes, RD- form, bits {abcdei, fghj}
    localparam logic [9:0] START_COMMA          = 10'b001111_1010; // K28.5
    localparam logic [9:0] END_COMMA            = 10'b001111_1001; // K28.1
    localparam logic [9:0] RESEND_PACKET0_COMMA = 10'b001111_0100; // K28.0
    localparam logic [9:0] RESEND_PACKET1_COMMA = 10'b001111_0101; // K28.2
    localparam logic [9:0] RESEND_PACKET2_COMMA = 10'b001111_0011; // K28.3
    localparam logic [9:0] RESEND_PACKET3_COMMA = 10'b001111_0010; // K28.4
    localparam logic [9:0] ACK_COMMA            = 10'b001111_0110; // K28.6
    localparam logic [9:0] NACK_COMMA           = 10'b001111_1000; // K28.7

    // transmit request payload word
    typedef logic [`PHY_WORD_W-1:0] tx_word_t;

    // link sequence number, sits in the low byte of a control request
    typedef logic [7:0] seq_t;

endpackage

`default_nettype wire

/* include/phy_link_params.svh */
// ==================================================
// flit geometry for the link PHY transmit path
// include wherever a flit or symbol width is needed
// ==================================================
`ifndef PHY_LINK_PARAMS_SVH
`define PHY_LINK_PARAMS_SVH

// raw bytes carried by one data flit
`define PHY_BYTES 5

// one 8b/10b symbol, also the width of a comma header
`define PHY_SYM_W 10

// encoded flit on the serializer side
`define PHY_FLIT_W 50

// raw payload word before encoding
`define PHY_WORD_W 40

`endif
